// File: hw/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// datapath width, 64 works as well
`define CSR_XLEN 32

// machine-mode CSR addresses
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MVENDORID 12'hf11
`define CSR_ADDR_MARCHID   12'hf12

// read-only id words
`define CSR_MVENDORID_VAL `CSR_XLEN'(32'h7973_7978)
`define CSR_MARCHID_VAL   `CSR_XLEN'(32'h015f_de77)

// mstatus interrupt-enable stack
`define CSR_MSTATUS_MIE_IDX  3
`define CSR_MSTATUS_MPIE_IDX 7

// mcause codes
`define CSR_CAUSE_ECALL_M 11
`define CSR_CAUSE_ILLEGAL 2

// SYSTEM opcode and privileged funct12 encodings
`define CSR_OPCODE_SYSTEM  7'b111_0011
`define CSR_FUNCT12_ECALL  12'h000
`define CSR_FUNCT12_MRET   12'h302

`endif

// File: hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

  // Zicsr operation, taken from funct3[1:0]
  typedef enum logic [1:0] {
    csr_op_none = 2'b00,
    csr_op_rw   = 2'b01,
    csr_op_rs   = 2'b10,
    csr_op_rc   = 2'b11
  } csr_op_e;

  // csrrw/csrrs/csrrc and immediate forms
  typedef struct packed {
    logic [11:0] csr_addr;
    // rs1 index, or zimm for the immediate forms
    logic [4:0]  src;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } csr_fmt_t;

  // ecall/mret, told apart by funct12
  typedef struct packed {
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } priv_fmt_t;

  // one SYSTEM word, two decodes
  // funct3 != 0 means a CSR access, funct3 == 0 means ecall/mret
  typedef union packed {
    csr_fmt_t  csr;
    priv_fmt_t priv;
  } csr_insn_u;

endpackage

`default_nettype wire

// File: hw/csr_op_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_op_alu (
  input  csr_pkg::csr_insn_u   insn,
  input  logic [`CSR_XLEN-1:0] rs1_data,
  input  logic [`CSR_XLEN-1:0] old_value,
  output logic                 is_csr,
  output logic                 csr_write,
  output logic [`CSR_XLEN-1:0] new_value
);
  import csr_pkg::*;

  csr_op_e              op;
  logic                 is_system;
  logic                 use_imm;
  logic                 src_zero;
  logic [`CSR_XLEN-1:0] operand;

  assign is_system = (insn.csr.opcode == `CSR_OPCODE_SYSTEM);
  assign use_imm   = insn.csr.funct3[2];
  assign src_zero  = (insn.csr.src == 5'd0);

  // funct3 of 000 and 100 are not CSR accesses
  assign is_csr = is_system && (insn.csr.funct3[1:0] != 2'b00);

  always_comb begin
    op = csr_op_none;
    if (is_system) begin
      case (insn.csr.funct3[1:0])
        2'b01:   op = csr_op_rw;
        2'b10:   op = csr_op_rs;
        2'b11:   op = csr_op_rc;
        default: op = csr_op_none;
      endcase
    end
  end

  // zimm is zero-extended
  assign operand = use_imm ? `CSR_XLEN'(insn.csr.src) : rs1_data;

  always_comb begin
    case (op)
      csr_op_rw: new_value = operand;
      csr_op_rs: new_value = old_value | operand;
      csr_op_rc: new_value = old_value & ~operand;
      default:   new_value = old_value;
    endcase
  end

  // rs/rc with x0 or zimm 0 only read, so a read-only CSR stays legal
  always_comb begin
    case (op)
      csr_op_rw: csr_write = 1'b1;
      csr_op_rs: csr_write = !src_zero;
      csr_op_rc: csr_write = !src_zero;
      default:   csr_write = 1'b0;
    endcase
  end

  // write intent only ever comes from a decoded CSR access
  always_comb begin
    assert final (!csr_write || is_csr)
      else $error("csr_op_alu: write intent without a CSR instruction");
  end

endmodule

`default_nettype wire

// File: hw/priv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module priv_ctrl (
  input  logic                 exu_valid,
  input  csr_pkg::csr_insn_u   insn,
  input  logic                 is_csr,
  input  logic                 csr_write,
  input  logic                 addr_known,
  input  logic                 addr_read_only,
  input  logic [`CSR_XLEN-1:0] mtvec,
  input  logic [`CSR_XLEN-1:0] mepc,
  output logic                 csr_commit,
  output logic                 trap_take,
  output logic [`CSR_XLEN-1:0] trap_cause,
  output logic                 mret_take,
  output logic                 rd_wen,
  output logic                 redirect,
  output logic [`CSR_XLEN-1:0] redirect_pc,
  output logic                 illegal
);

  logic is_priv;
  logic is_ecall;
  logic is_mret;
  logic access_bad;
  logic trap_req;

  // privileged view, rs1 and rd must be x0
  assign is_priv = (insn.priv.opcode == `CSR_OPCODE_SYSTEM) &&
                   (insn.priv.funct3 == 3'b000) &&
                   (insn.priv.rs1 == 5'd0) &&
                   (insn.priv.rd == 5'd0);

  assign is_ecall = is_priv && (insn.priv.funct12 == `CSR_FUNCT12_ECALL);
  assign is_mret  = is_priv && (insn.priv.funct12 == `CSR_FUNCT12_MRET);

  // unknown CSR, or a real write to a read-only one
  assign access_bad = is_csr && (!addr_known || (csr_write && addr_read_only));

  assign trap_req = is_ecall || access_bad;

  assign trap_take  = exu_valid && trap_req;
  assign mret_take  = exu_valid && is_mret;
  assign illegal    = exu_valid && access_bad;

  // illegal wins the cause, ecall cannot be a CSR access anyway
  assign trap_cause = access_bad ? `CSR_XLEN'(`CSR_CAUSE_ILLEGAL)
                                 : `CSR_XLEN'(`CSR_CAUSE_ECALL_M);

  // old value goes to rd for every legal access, even pure writes
  assign rd_wen     = exu_valid && is_csr && !access_bad;
  assign csr_commit = exu_valid && csr_write && !trap_req;

  assign redirect    = trap_take || mret_take;
  assign redirect_pc = trap_take ? mtvec : mepc;

  // a redirect needs a strobe and never comes with an rd write
  always_comb begin
    assert final (!redirect || (exu_valid && !rd_wen))
      else $error("priv_ctrl: redirect without strobe or with rd write");
  end

endmodule

`default_nettype wire

// File: hw/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  csr_pkg::csr_insn_u   insn,
  input  logic [`CSR_XLEN-1:0] new_value,
  input  logic                 csr_commit,
  input  logic                 trap_take,
  input  logic [`CSR_XLEN-1:0] trap_cause,
  input  logic                 mret_take,
  input  logic [`CSR_XLEN-1:0] pc,
  output logic [`CSR_XLEN-1:0] old_value,
  output logic                 addr_known,
  output logic                 addr_read_only,
  output logic [`CSR_XLEN-1:0] mtvec,
  output logic [`CSR_XLEN-1:0] mepc
);

  // register index of the writable CSRs
  localparam logic [1:0] idx_mstatus = 2'd0;
  localparam logic [1:0] idx_mtvec   = 2'd1;
  localparam logic [1:0] idx_mepc    = 2'd2;
  localparam logic [1:0] idx_mcause  = 2'd3;

  logic [`CSR_XLEN-1:0] csr_q [4];
  logic [11:0]          addr;
  logic [1:0]           reg_idx;
  logic                 reg_hit;

  assign addr = insn.csr.csr_addr;

  always_comb begin
    reg_idx        = idx_mstatus;
    reg_hit        = 1'b0;
    addr_known     = 1'b1;
    addr_read_only = 1'b0;
    case (addr)
      `CSR_ADDR_MSTATUS: begin
        reg_idx = idx_mstatus;
        reg_hit = 1'b1;
      end
      `CSR_ADDR_MTVEC: begin
        reg_idx = idx_mtvec;
        reg_hit = 1'b1;
      end
      `CSR_ADDR_MEPC: begin
        reg_idx = idx_mepc;
        reg_hit = 1'b1;
      end
      `CSR_ADDR_MCAUSE: begin
        reg_idx = idx_mcause;
        reg_hit = 1'b1;
      end
      `CSR_ADDR_MVENDORID: begin
        addr_read_only = 1'b1;
      end
      `CSR_ADDR_MARCHID: begin
        addr_read_only = 1'b1;
      end
      default: begin
        addr_known = 1'b0;
      end
    endcase
  end

  // zero-cycle read, ids are constants
  always_comb begin
    if (reg_hit) begin
      old_value = csr_q[reg_idx];
    end else if (addr == `CSR_ADDR_MVENDORID) begin
      old_value = `CSR_MVENDORID_VAL;
    end else if (addr == `CSR_ADDR_MARCHID) begin
      old_value = `CSR_MARCHID_VAL;
    end else begin
      old_value = '0;
    end
  end

  assign mtvec = csr_q[idx_mtvec];
  assign mepc  = csr_q[idx_mepc];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        csr_q[i] <= '0;
      end
    end else begin
      if (csr_commit && reg_hit) begin
        csr_q[reg_idx] <= new_value;
      end
      // trap entry pushes MIE into MPIE
      if (trap_take) begin
        csr_q[idx_mepc]   <= pc;
        csr_q[idx_mcause] <= trap_cause;
        csr_q[idx_mstatus][`CSR_MSTATUS_MPIE_IDX] <=
          csr_q[idx_mstatus][`CSR_MSTATUS_MIE_IDX];
        csr_q[idx_mstatus][`CSR_MSTATUS_MIE_IDX] <= 1'b0;
      end
      // mret pops it back
      if (mret_take) begin
        csr_q[idx_mstatus][`CSR_MSTATUS_MIE_IDX] <=
          csr_q[idx_mstatus][`CSR_MSTATUS_MPIE_IDX];
        csr_q[idx_mstatus][`CSR_MSTATUS_MPIE_IDX] <= 1'b1;
      end
    end
  end

  // priv_ctrl never asks for both stack moves at once
  trap_mret_excl: assert property (@(posedge clk) disable iff (rst)
    !(trap_take && mret_take))
    else $error("csr_regfile: trap and mret in the same cycle");

  // commits only reach writable CSRs
  commit_hits_reg: assert property (@(posedge clk) disable iff (rst)
    csr_commit |-> reg_hit)
    else $error("csr_regfile: commit to a non-writable address");

endmodule

`default_nettype wire

// File: hw/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 exu_valid,
  input  csr_pkg::csr_insn_u   insn,
  input  logic [`CSR_XLEN-1:0] pc,
  input  logic [`CSR_XLEN-1:0] rs1_data,
  output logic                 rd_wen,
  output logic [`CSR_XLEN-1:0] rd_data,
  output logic                 redirect,
  output logic [`CSR_XLEN-1:0] redirect_pc,
  output logic                 illegal
);

  // operation decode
  logic                 is_csr;
  logic                 csr_write;
  logic [`CSR_XLEN-1:0] new_value;

  // register file read side
  logic                 addr_known;
  logic                 addr_read_only;
  logic [`CSR_XLEN-1:0] old_value;
  logic [`CSR_XLEN-1:0] mtvec;
  logic [`CSR_XLEN-1:0] mepc;

  // state update requests
  logic                 csr_commit;
  logic                 trap_take;
  logic [`CSR_XLEN-1:0] trap_cause;
  logic                 mret_take;

  csr_op_alu i_csr_op_alu (
    .insn      (insn),
    .rs1_data  (rs1_data),
    .old_value (old_value),
    .is_csr    (is_csr),
    .csr_write (csr_write),
    .new_value (new_value)
  );

  priv_ctrl i_priv_ctrl (
    .exu_valid      (exu_valid),
    .insn           (insn),
    .is_csr         (is_csr),
    .csr_write      (csr_write),
    .addr_known     (addr_known),
    .addr_read_only (addr_read_only),
    .mtvec          (mtvec),
    .mepc           (mepc),
    .csr_commit     (csr_commit),
    .trap_take      (trap_take),
    .trap_cause     (trap_cause),
    .mret_take      (mret_take),
    .rd_wen         (rd_wen),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .illegal        (illegal)
  );

  csr_regfile i_csr_regfile (
    .clk            (clk),
    .rst            (rst),
    .insn           (insn),
    .new_value      (new_value),
    .csr_commit     (csr_commit),
    .trap_take      (trap_take),
    .trap_cause     (trap_cause),
    .mret_take      (mret_take),
    .pc             (pc),
    .old_value      (old_value),
    .addr_known     (addr_known),
    .addr_read_only (addr_read_only),
    .mtvec          (mtvec),
    .mepc           (mepc)
  );

  // old CSR value goes to rd unchanged
  assign rd_data = old_value;

endmodule

`default_nettype wire

// File: sim/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_unit_tb;
  import csr_pkg::*;

  // reset, ids, rmw with random, ecall, mret, illegal, gating
  localparam int test_cycles = 10 + 6 + 232 + 8 + 7 + 8 + 16;
  localparam int margin_cycles = 100;

  logic                 clk;
  logic                 rst;
  logic                 exu_valid;
  csr_insn_u            insn;
  logic [`CSR_XLEN-1:0] pc;
  logic [`CSR_XLEN-1:0] rs1_data;
  logic                 rd_wen;
  logic [`CSR_XLEN-1:0] rd_data;
  logic                 redirect;
  logic [`CSR_XLEN-1:0] redirect_pc;
  logic                 illegal;

  // reference model state and its next value
  logic [`CSR_XLEN-1:0] m_status;
  logic [`CSR_XLEN-1:0] m_tvec;
  logic [`CSR_XLEN-1:0] m_epc;
  logic [`CSR_XLEN-1:0] m_cause;
  logic [`CSR_XLEN-1:0] n_status;
  logic [`CSR_XLEN-1:0] n_tvec;
  logic [`CSR_XLEN-1:0] n_epc;
  logic [`CSR_XLEN-1:0] n_cause;

  logic                 exp_rd_wen;
  logic [`CSR_XLEN-1:0] exp_rd_data;
  logic                 exp_redirect;
  logic [`CSR_XLEN-1:0] exp_redirect_pc;
  logic                 exp_illegal;

  string                test_name;
  int                   errors;
  int                   test_errs;
  int                   tests_run;
  int                   strobes;
  int                   seed;
  logic [`CSR_XLEN-1:0] cur_pc;
  logic [11:0]          rw_addrs [4];
  logic [2:0]           ops [6];

  csr_unit i_csr_unit (
    .clk         (clk),
    .rst         (rst),
    .exu_valid   (exu_valid),
    .insn        (insn),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rd_wen      (rd_wen),
    .rd_data     (rd_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .illegal     (illegal)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] csr_word(input logic [2:0] funct3, input logic [11:0] addr,
                                           input logic [4:0] src);
    return {addr, src, funct3, 5'd1, `CSR_OPCODE_SYSTEM};
  endfunction

  function automatic logic [31:0] priv_word(input logic [11:0] funct12);
    return {funct12, 13'd0, `CSR_OPCODE_SYSTEM};
  endfunction

  task automatic report_value(input string what, input logic [`CSR_XLEN-1:0] expected,
                              input logic [`CSR_XLEN-1:0] actual);
    errors++;
    test_errs++;
    $display("Fail %s %s expected %h actual %h", test_name, what, expected, actual);
  endtask

  // expected outputs and next state, straight from the Zicsr and trap rules
  task automatic predict(input logic [31:0] word, input logic [`CSR_XLEN-1:0] at_pc,
                         input logic [`CSR_XLEN-1:0] rs1);
    logic [11:0]          addr;
    logic [4:0]           src;
    logic [2:0]           f3;
    logic                 acc;
    logic                 ecall;
    logic                 mret;
    logic                 known;
    logic                 ro;
    logic                 wr;
    logic                 bad;
    logic [`CSR_XLEN-1:0] old;
    logic [`CSR_XLEN-1:0] opnd;
    logic [`CSR_XLEN-1:0] nv;
    addr  = word[31:20];
    src   = word[19:15];
    f3    = word[14:12];
    acc   = (word[6:0] == `CSR_OPCODE_SYSTEM) && (f3[1:0] != 2'b00);
    ecall = (word[6:0] == `CSR_OPCODE_SYSTEM) && (word[19:7] == '0) && (addr == 12'h000);
    mret  = (word[6:0] == `CSR_OPCODE_SYSTEM) && (word[19:7] == '0) && (addr == 12'h302);
    known = 1'b1;
    ro    = 1'b0;
    case (addr)
      `CSR_ADDR_MSTATUS:   old = m_status;
      `CSR_ADDR_MTVEC:     old = m_tvec;
      `CSR_ADDR_MEPC:      old = m_epc;
      `CSR_ADDR_MCAUSE:    old = m_cause;
      `CSR_ADDR_MVENDORID: begin
        old = `CSR_MVENDORID_VAL;
        ro  = 1'b1;
      end
      `CSR_ADDR_MARCHID: begin
        old = `CSR_MARCHID_VAL;
        ro  = 1'b1;
      end
      default: begin
        old   = '0;
        known = 1'b0;
      end
    endcase
    opnd = f3[2] ? `CSR_XLEN'(src) : rs1;
    wr   = acc && ((f3[1:0] == 2'b01) || (src != 5'd0));
    case (f3[1:0])
      2'b01:   nv = opnd;
      2'b10:   nv = old | opnd;
      default: nv = old & ~opnd;
    endcase
    bad = acc && (!known || (wr && ro));

    exp_rd_wen      = acc && !bad;
    exp_rd_data     = old;
    exp_illegal     = bad;
    exp_redirect    = ecall || mret || bad;
    exp_redirect_pc = (ecall || bad) ? m_tvec : m_epc;

    n_status = m_status;
    n_tvec   = m_tvec;
    n_epc    = m_epc;
    n_cause  = m_cause;
    if (wr && !bad) begin
      case (addr)
        `CSR_ADDR_MSTATUS: n_status = nv;
        `CSR_ADDR_MTVEC:   n_tvec = nv;
        `CSR_ADDR_MEPC:    n_epc = nv;
        `CSR_ADDR_MCAUSE:  n_cause = nv;
        default:           n_cause = m_cause;
      endcase
    end
    if (ecall || bad) begin
      n_epc   = at_pc;
      n_cause = bad ? `CSR_XLEN'(`CSR_CAUSE_ILLEGAL) : `CSR_XLEN'(`CSR_CAUSE_ECALL_M);
      n_status[`CSR_MSTATUS_MPIE_IDX] = m_status[`CSR_MSTATUS_MIE_IDX];
      n_status[`CSR_MSTATUS_MIE_IDX]  = 1'b0;
    end
    if (mret) begin
      n_status[`CSR_MSTATUS_MIE_IDX]  = m_status[`CSR_MSTATUS_MPIE_IDX];
      n_status[`CSR_MSTATUS_MPIE_IDX] = 1'b1;
    end
  endtask

  task automatic retire();
    m_status = n_status;
    m_tvec   = n_tvec;
    m_epc    = n_epc;
    m_cause  = n_cause;
  endtask

  // one strobe, inputs change 2 ns after the edge
  task automatic issue(input logic [31:0] word, input logic [`CSR_XLEN-1:0] rs1);
    predict(word, cur_pc, rs1);
    insn      = word;
    pc        = cur_pc;
    rs1_data  = rs1;
    exu_valid = 1'b1;
    @(posedge clk);
    #2;
    exu_valid = 1'b0;
    retire();
    cur_pc = cur_pc + 4;
    strobes++;
  endtask

  // junk on the inputs with no strobe
  task automatic idle(input logic [31:0] junk);
    exu_valid = 1'b0;
    insn      = junk;
    rs1_data  = `CSR_XLEN'($random(seed));
    @(posedge clk);
    #2;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s finished with %0d errors", test_name, test_errs);
  endtask

  task automatic read_back_all();
    for (int i = 0; i < 4; i++) begin
      issue(csr_word(3'b010, rw_addrs[i], 5'd0), '0);
    end
  endtask

  rd_wen_check: assert property (@(posedge clk) disable iff (rst)
    exu_valid |-> (rd_wen == exp_rd_wen))
    else report_value("rd_wen", `CSR_XLEN'(exp_rd_wen), `CSR_XLEN'($sampled(rd_wen)));

  rd_data_check: assert property (@(posedge clk) disable iff (rst)
    (exu_valid && exp_rd_wen) |-> (rd_data == exp_rd_data))
    else report_value("rd_data", exp_rd_data, $sampled(rd_data));

  redirect_check: assert property (@(posedge clk) disable iff (rst)
    exu_valid |-> (redirect == exp_redirect))
    else report_value("redirect", `CSR_XLEN'(exp_redirect), `CSR_XLEN'($sampled(redirect)));

  redirect_pc_check: assert property (@(posedge clk) disable iff (rst)
    (exu_valid && exp_redirect) |-> (redirect_pc == exp_redirect_pc))
    else report_value("redirect_pc", exp_redirect_pc, $sampled(redirect_pc));

  illegal_check: assert property (@(posedge clk) disable iff (rst)
    exu_valid |-> (illegal == exp_illegal))
    else report_value("illegal", `CSR_XLEN'(exp_illegal), `CSR_XLEN'($sampled(illegal)));

  // no strobe, nothing may fire
  quiet_check: assert property (@(posedge clk) disable iff (rst)
    !exu_valid |-> !(rd_wen || redirect || illegal))
    else report_value("idle_outputs", '0,
                      `CSR_XLEN'({$sampled(rd_wen), $sampled(redirect), $sampled(illegal)}));

  initial begin
    #((test_cycles + margin_cycles) * 20);
    $display("timeout: tests did not finish within %0d cycles", test_cycles + margin_cycles);
    $display("sim failed");
    $finish;
  end

  initial begin
    logic [11:0]          a;
    logic [2:0]           f;
    logic [4:0]           s;
    logic [`CSR_XLEN-1:0] v;
    clk       = 1'b0;
    rst       = 1'b1;
    exu_valid = 1'b0;
    insn      = '0;
    pc        = '0;
    rs1_data  = '0;
    m_status  = '0;
    m_tvec    = '0;
    m_epc     = '0;
    m_cause   = '0;
    errors    = 0;
    tests_run = 0;
    strobes   = 0;
    seed      = 12628;
    cur_pc    = `CSR_XLEN'(32'h0000_1000);
    rw_addrs  = '{`CSR_ADDR_MSTATUS, `CSR_ADDR_MTVEC, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE};
    ops       = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};
    exp_rd_wen      = 1'b0;
    exp_rd_data     = '0;
    exp_redirect    = 1'b0;
    exp_redirect_pc = '0;
    exp_illegal     = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    start_test("reset_ids");
    read_back_all();
    issue(csr_word(3'b010, `CSR_ADDR_MVENDORID, 5'd0), '0);
    issue(csr_word(3'b010, `CSR_ADDR_MARCHID, 5'd0), '0);
    end_test();

    start_test("rmw");
    for (int i = 0; i < 4; i++) begin
      issue(csr_word(3'b001, rw_addrs[i], 5'd2), 32'ha5a5_0f0f + i);
      issue(csr_word(3'b010, rw_addrs[i], 5'd3), 32'h0000_ff00);
      issue(csr_word(3'b011, rw_addrs[i], 5'd4), 32'h0f00_000f);
      issue(csr_word(3'b101, rw_addrs[i], 5'd21), '0);
      issue(csr_word(3'b110, rw_addrs[i], 5'd10), '0);
      issue(csr_word(3'b111, rw_addrs[i], 5'd1), '0);
    end
    read_back_all();
    for (int n = 0; n < 200; n++) begin
      a = rw_addrs[2'($random(seed))];
      f = ops[3'($unsigned($random(seed)) % 32'd6)];
      s = 5'($random(seed));
      v = `CSR_XLEN'($random(seed));
      issue(csr_word(f, a, s), v);
    end
    read_back_all();
    end_test();

    start_test("ecall");
    issue(csr_word(3'b001, `CSR_ADDR_MTVEC, 5'd1), 32'h8000_0100);
    issue(csr_word(3'b001, `CSR_ADDR_MSTATUS, 5'd1), 32'h0000_0008);
    issue(priv_word(`CSR_FUNCT12_ECALL), '0);
    issue(csr_word(3'b010, `CSR_ADDR_MEPC, 5'd0), '0);
    issue(csr_word(3'b010, `CSR_ADDR_MCAUSE, 5'd0), '0);
    issue(csr_word(3'b010, `CSR_ADDR_MSTATUS, 5'd0), '0);
    // MIE is clear now, so MPIE drops to 0
    issue(priv_word(`CSR_FUNCT12_ECALL), '0);
    issue(csr_word(3'b010, `CSR_ADDR_MSTATUS, 5'd0), '0);
    end_test();

    start_test("mret");
    issue(csr_word(3'b001, `CSR_ADDR_MEPC, 5'd1), 32'h0000_2000);
    issue(csr_word(3'b001, `CSR_ADDR_MSTATUS, 5'd1), 32'h0000_0080);
    issue(priv_word(`CSR_FUNCT12_MRET), '0);
    issue(csr_word(3'b010, `CSR_ADDR_MSTATUS, 5'd0), '0);
    issue(csr_word(3'b001, `CSR_ADDR_MSTATUS, 5'd1), '0);
    issue(priv_word(`CSR_FUNCT12_MRET), '0);
    issue(csr_word(3'b010, `CSR_ADDR_MSTATUS, 5'd0), '0);
    end_test();

    start_test("illegal");
    issue(csr_word(3'b010, 12'h7c0, 5'd0), '0);
    issue(csr_word(3'b001, 12'h7c0, 5'd5), 32'h1234_5678);
    issue(csr_word(3'b001, `CSR_ADDR_MARCHID, 5'd6), 32'hdead_beef);
    issue(csr_word(3'b010, `CSR_ADDR_MARCHID, 5'd0), '0);
    issue(csr_word(3'b111, `CSR_ADDR_MVENDORID, 5'd0), '0);
    issue(csr_word(3'b110, `CSR_ADDR_MVENDORID, 5'd1), '0);
    issue(csr_word(3'b010, `CSR_ADDR_MCAUSE, 5'd0), '0);
    issue(csr_word(3'b010, `CSR_ADDR_MTVEC, 5'd0), '0);
    end_test();

    start_test("gating");
    issue(csr_word(3'b001, `CSR_ADDR_MTVEC, 5'd1), 32'h0000_4000);
    for (int k = 0; k < 4; k++) begin
      idle(csr_word(3'b001, `CSR_ADDR_MTVEC, 5'd3));
      idle(priv_word(`CSR_FUNCT12_ECALL));
    end
    issue(csr_word(3'b010, `CSR_ADDR_MTVEC, 5'd0), '0);
    issue(csr_word(3'b010, `CSR_ADDR_MEPC, 5'd0), '0);
    issue(csr_word(3'b010, `CSR_ADDR_MSTATUS, 5'd0), '0);
    // back-to-back, each strobe sees the one before
    issue(csr_word(3'b001, `CSR_ADDR_MEPC, 5'd1), 32'h0000_3000);
    issue(csr_word(3'b010, `CSR_ADDR_MEPC, 5'd1), 32'h0000_0010);
    issue(csr_word(3'b011, `CSR_ADDR_MEPC, 5'd1), 32'h0000_3000);
    issue(csr_word(3'b010, `CSR_ADDR_MEPC, 5'd0), '0);
    end_test();

    $display("tests %0d, strobes %0d, errors %0d", tests_run, strobes, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/csr_pkg.sv
hw/csr_op_alu.sv
hw/priv_ctrl.sv
hw/csr_regfile.sv
hw/csr_unit.sv
sim/csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the csr_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f flist.f --top-module csr_unit_tb \
  -o csr_unit_tb > build.log 2>&1 &&
  ./obj_dir/csr_unit_tb > sim.log 2>&1 ||
  echo "sim failed" >> sim.log

cat build.log sim.log
if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0
